// File: rtl/n64a_pkg.sv
package n64a_pkg;

  ////////////////////
  // video bus widths

  localparam int COLOR_W = 7;  // one colour byte on D_i[6:0]
  localparam int SYNC_W  = 4;  // sync nibble on D_i[3:0]

  ////////////////////
  // frame info

  localparam int LINE_CNT_W  = 10;   // enough for a PAL frame, saturates beyond
  localparam int PAL_LINE_TH = 300;  // more lines than this -> PAL

  ////////////////////
  // blur estimator

  localparam int TREND_W = 9;  // trend filter width
  // start in the middle, MSB set means no blur assumed
  localparam logic [TREND_W-1:0] TREND_INIT = {1'b1, {(TREND_W-1){1'b0}}};

  ////////////////////
  // register map, word addresses

  localparam int REG_CTRL = 0;
  localparam int REG_STAT = 1;

  ////////////////////
  // structs

  // all active low, bit 3 down to bit 0 as on the bus
  typedef struct packed {
    logic nvsync;
    logic nclamp;
    logic nhsync;
    logic ncsync;
  } sync_t;

  // one rebuilt pixel, 4 + 3*7 = 25 bits
  typedef struct packed {
    sync_t              sync;
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } pixel_t;

  typedef struct packed {
    logic frame_start;  // one cycle strobe per frame
    logic n64_480i;     // interlaced mode
    logic pal;          // last frame had PAL line count
  } vinfo_t;

  typedef struct packed {
    logic nforce_deblur;  // 1 -> automatic, 0 -> manual
    logic ndeblur_man;    // manual setting, active low
  } dbl_ctrl_t;

endpackage

// File: rtl/n64_vdemux.sv
`timescale 1ns/1ps

module n64_vdemux
  import n64a_pkg::*;
(
  input  logic               nCLK,
  input  logic               nRST,
  input  logic               nDSYNC_i,
  input  logic [COLOR_W-1:0] D_i,
  output pixel_t             pix_o,
  output logic               pix_valid_o,
  output logic               vsync_fall_o
);

  ////////////////////
  // declarations

  logic [1:0]         data_cnt;  // 0 -> r next, 1 -> g next, 2 -> b next, 3 -> idle
  sync_t              sync_in;   // sync nibble as seen on the bus
  sync_t              sync_q;    // latched nibble of the current pixel
  logic [COLOR_W-1:0] r_q;       // colour holding regs
  logic [COLOR_W-1:0] g_q;

  assign sync_in = sync_t'(D_i[SYNC_W-1:0]);

  ////////////////////
  // byte counter and strobes

  always_ff @(negedge nCLK) begin
    if (!nRST) begin
      data_cnt     <= 2'd3;  // wait for the first sync byte
      sync_q       <= '1;    // all sync inactive, no false vsync edge
      pix_valid_o  <= 1'b0;
      vsync_fall_o <= 1'b0;
    end else begin
      pix_valid_o  <= 1'b0;  // strobes default low
      vsync_fall_o <= 1'b0;
      if (!nDSYNC_i) begin  // sync byte restarts the pixel
        data_cnt     <= 2'd0;
        sync_q       <= sync_in;
        // nvsync high on the last sync byte and low now -> new frame
        vsync_fall_o <= sync_q.nvsync & ~sync_in.nvsync;
      end else if (data_cnt != 2'd3) begin
        data_cnt    <= data_cnt + 2'd1;
        pix_valid_o <= (data_cnt == 2'd2);  // b byte completes the pixel
      end
    end
  end

  ////////////////////
  // colour capture, payload only

  always_ff @(negedge nCLK) begin
    if (nDSYNC_i) begin
      case (data_cnt)
        2'd0: r_q <= D_i;
        2'd1: g_q <= D_i;
        2'd2: begin
          pix_o.sync <= sync_q;  // sync belongs to this pixel
          pix_o.r    <= r_q;
          pix_o.g    <= g_q;
          pix_o.b    <= D_i;     // b straight from the bus
        end
        default: ;               // stray bytes after b are dropped
      endcase
    end
  end

endmodule

// File: rtl/n64_vinfo.sv
`timescale 1ns/1ps

module n64_vinfo
  import n64a_pkg::*;
(
  input  logic   nCLK,
  input  logic   nRST,
  input  pixel_t pix_i,
  input  logic   pix_valid_i,
  input  logic   vsync_fall_i,
  output vinfo_t vinfo_o
);

  logic                  nhsync_q;       // nhsync of the last pixel
  logic                  hs_fall;
  logic                  hflag_now;      // hsync low at this vsync fall
  logic                  hflag_q;        // same flag, previous frame
  logic [LINE_CNT_W-1:0] line_cnt;
  logic                  frame_start_q;
  logic                  n64_480i_q;
  logic                  pal_q;

  assign hs_fall   = pix_valid_i & nhsync_q & ~pix_i.sync.nhsync;
  assign hflag_now = ~nhsync_q;  // last pixel before the vsync fall

  ////////////////////
  // line count and frame flags

  always_ff @(negedge nCLK) begin
    if (!nRST) begin
      nhsync_q      <= 1'b1;
      hflag_q       <= 1'b0;
      line_cnt      <= '0;
      frame_start_q <= 1'b0;
      n64_480i_q    <= 1'b0;
      pal_q         <= 1'b0;
    end else begin
      frame_start_q <= vsync_fall_i;  // one more stage behind the demux
      if (pix_valid_i)
        nhsync_q <= pix_i.sync.nhsync;
      if (vsync_fall_i) begin
        line_cnt   <= '0;
        pal_q      <= (line_cnt > LINE_CNT_W'(PAL_LINE_TH));  // held for the frame
        // interlaced frames land vsync alternately on and off a half line
        n64_480i_q <= hflag_now ^ hflag_q;
        hflag_q    <= hflag_now;
      end else if (hs_fall && !(&line_cnt)) begin
        line_cnt <= line_cnt + 1'b1;  // saturate, never wrap into NTSC range
      end
    end
  end

  assign vinfo_o = '{frame_start: frame_start_q, n64_480i: n64_480i_q, pal: pal_q};

endmodule

// File: rtl/n64_deblur.sv
`timescale 1ns/1ps

module n64_deblur
  import n64a_pkg::*;
(
  input  logic      nCLK,
  input  logic      nRST,
  input  pixel_t    pix_i,
  input  logic      pix_valid_i,
  input  vinfo_t    vinfo_i,
  input  dbl_ctrl_t ctrl_i,
  output logic      ndo_deblur_o,
  output logic      nblur_est_o
);

  ////////////////////
  // declarations

  logic [2:0][2:0]     msb_cur;   // top three bits of r, g, b
  logic [2:0][2:0]     msb_q;     // same for the previous pixel
  logic [2:0][1:0]     grad_cur;  // {up, down} per colour
  logic [2:0][1:0]     grad_q;    // gradient into the last blur pixel
  logic                ncsync_q;
  logic                csync_rise;
  logic                blur_q;    // phase of the previous pixel
  logic                blur_pos;  // phase of this pixel
  logic                reversal;
  logic [1:0]          rev_cnt;   // saturating, per frame
  logic [TREND_W-1:0]  trend_q;
  logic [TREND_W-1:0]  trend_nxt;
  logic                run_estimation;  // low for the first frame after 480i
  logic                nblur_est_q;     // 1 -> no blur estimated
  logic                est_nxt;
  logic                ndo_deblur_q;

  // gradient between two msb slices, flat gives 2'b00
  function automatic logic [1:0] grad_f(input logic [2:0] prev, input logic [2:0] cur);
    grad_f = {(cur > prev), (cur < prev)};
  endfunction

  ////////////////////
  // gradient heuristic

  always_comb begin
    msb_cur[2] = pix_i.r[COLOR_W-1 -: 3];
    msb_cur[1] = pix_i.g[COLOR_W-1 -: 3];
    msb_cur[0] = pix_i.b[COLOR_W-1 -: 3];
    for (int i = 0; i < 3; i++)
      grad_cur[i] = grad_f(msb_q[i], msb_cur[i]);

    csync_rise = ~ncsync_q & pix_i.sync.ncsync;     // line start
    blur_pos   = csync_rise ? ~vinfo_i.pal : ~blur_q;  // pal lines start sharp

    // a stored flat gradient never xors to 2'b11, so flat cannot count
    reversal = (&(grad_cur[2] ^ grad_q[2])) &
               (&(grad_cur[1] ^ grad_q[1])) &
               (&(grad_cur[0] ^ grad_q[0]));
  end

  always_ff @(negedge nCLK) begin  // pixel history, payload only
    if (pix_valid_i) begin
      msb_q <= msb_cur;
      if (blur_pos)
        grad_q <= grad_cur;  // remember what the blur pixel did
    end
  end

  ////////////////////
  // trend filter

  always_comb begin
    trend_nxt = trend_q;
    est_nxt   = nblur_est_q;
    if (!vinfo_i.n64_480i && run_estimation) begin
      if (&rev_cnt)
        trend_nxt = (&trend_q) ? trend_q : trend_q + 1'b1;  // sharp frame
      else
        trend_nxt = (|trend_q) ? trend_q - 1'b1 : trend_q;  // looks blurry
      est_nxt = trend_q[TREND_W-1];  // estimate from the old trend
    end
  end

  ////////////////////
  // control state and decision

  always_ff @(negedge nCLK) begin
    if (!nRST) begin
      ncsync_q       <= 1'b1;
      blur_q         <= 1'b0;
      rev_cnt        <= 2'd0;
      trend_q        <= TREND_INIT;
      run_estimation <= 1'b0;
      nblur_est_q    <= 1'b1;
      ndo_deblur_q   <= 1'b1;  // de-blur off until estimated
    end else begin
      if (pix_valid_i) begin
        ncsync_q <= pix_i.sync.ncsync;
        blur_q   <= blur_pos;
      end
      if (vinfo_i.frame_start) begin
        trend_q        <= trend_nxt;
        nblur_est_q    <= est_nxt;
        rev_cnt        <= 2'd0;
        run_estimation <= ~vinfo_i.n64_480i;  // skip one frame on the way out of 480i
        // new setting only here, never mid frame
        if (ctrl_i.nforce_deblur)
          ndo_deblur_q <= vinfo_i.n64_480i | est_nxt;
        else
          ndo_deblur_q <= vinfo_i.n64_480i | ctrl_i.ndeblur_man;
      end else if (pix_valid_i && !blur_pos && reversal && !(&rev_cnt)) begin
        rev_cnt <= rev_cnt + 2'd1;  // sharp pixel undid the blur pixel's step
      end
    end
  end

  assign ndo_deblur_o = ndo_deblur_q;
  assign nblur_est_o  = nblur_est_q;

endmodule

// File: rtl/n64a_cfg_wb.sv
`timescale 1ns/1ps

module n64a_cfg_wb
  import n64a_pkg::*;
#(
  parameter int ADDR_W = 4
) (
  input  logic              nCLK,
  input  logic              nRST,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  logic [31:0]       wb_dat_i,
  output logic [31:0]       wb_dat_o,
  output logic              wb_ack_o,
  input  vinfo_t            vinfo_i,
  input  logic              ndo_deblur_i,
  input  logic              nblur_est_i,
  output dbl_ctrl_t         ctrl_o
);

  logic        req;       // new request, not yet acked
  logic        hit_ctrl;
  logic        hit_stat;
  logic [31:0] rd_data;
  dbl_ctrl_t   ctrl_q;
  logic        ack_q;

  assign req      = wb_cyc_i & wb_stb_i & ~ack_q;  // no second ack while stb drops
  assign hit_ctrl = (wb_adr_i == ADDR_W'(REG_CTRL));
  assign hit_stat = (wb_adr_i == ADDR_W'(REG_STAT));

  ////////////////////
  // read mux

  always_comb begin
    rd_data = '0;  // unmapped reads as zero
    if (hit_ctrl)
      rd_data[1:0] = ctrl_q;
    else if (hit_stat)
      rd_data[3:0] = {vinfo_i.pal, vinfo_i.n64_480i, nblur_est_i, ndo_deblur_i};
  end

  ////////////////////
  // ack and control register

  always_ff @(negedge nCLK) begin
    if (!nRST) begin
      ack_q  <= 1'b0;
      ctrl_q <= '{nforce_deblur: 1'b1, ndeblur_man: 1'b1};  // automatic
    end else begin
      ack_q <= req;
      if (req && wb_we_i && hit_ctrl)
        ctrl_q <= dbl_ctrl_t'(wb_dat_i[1:0]);  // visible with ack
    end
  end

  always_ff @(negedge nCLK) begin
    if (req)
      wb_dat_o <= rd_data;  // status sampled at request time
  end

  assign wb_ack_o = ack_q;
  assign ctrl_o   = ctrl_q;

endmodule

// File: rtl/n64a_top.sv
`timescale 1ns/1ps

module n64a_top
  import n64a_pkg::*;
#(
  parameter int ADDR_W = 4
) (
  input  logic               nCLK,
  input  logic               nRST,
  input  logic               nDSYNC_i,
  input  logic [COLOR_W-1:0] D_i,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  logic [ADDR_W-1:0]  wb_adr_i,
  input  logic [31:0]        wb_dat_i,
  output logic [31:0]        wb_dat_o,
  output logic               wb_ack_o,
  output logic               ndo_deblur_o
);

  pixel_t    pix;         // rebuilt pixel
  logic      pix_valid;
  logic      vsync_fall;
  vinfo_t    vinfo;
  dbl_ctrl_t ctrl;        // host setting to estimator
  logic      nblur_est;

  ////////////////////
  // video path

  n64_vdemux u_vdemux (
    .nCLK        (nCLK),
    .nRST        (nRST),
    .nDSYNC_i    (nDSYNC_i),
    .D_i         (D_i),
    .pix_o       (pix),
    .pix_valid_o (pix_valid),
    .vsync_fall_o(vsync_fall)
  );

  n64_vinfo u_vinfo (
    .nCLK        (nCLK),
    .nRST        (nRST),
    .pix_i       (pix),
    .pix_valid_i (pix_valid),
    .vsync_fall_i(vsync_fall),
    .vinfo_o     (vinfo)
  );

  n64_deblur u_deblur (
    .nCLK        (nCLK),
    .nRST        (nRST),
    .pix_i       (pix),
    .pix_valid_i (pix_valid),
    .vinfo_i     (vinfo),
    .ctrl_i      (ctrl),
    .ndo_deblur_o(ndo_deblur_o),
    .nblur_est_o (nblur_est)
  );

  ////////////////////
  // host registers

  n64a_cfg_wb #(
    .ADDR_W(ADDR_W)
  ) u_cfg_wb (
    .nCLK        (nCLK),
    .nRST        (nRST),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .vinfo_i     (vinfo),
    .ndo_deblur_i(ndo_deblur_o),
    .nblur_est_i (nblur_est),
    .ctrl_o      (ctrl)
  );

endmodule

// File: tb/tb_n64a.sv
`timescale 1ns/1ps

module tb_n64a
  import n64a_pkg::*;
();

  localparam int ADDR_W    = 4;
  localparam int ACT_PX    = 6;    // active pixels per line
  localparam int NTSC_LN   = 20;   // short frame, well below PAL_LINE_TH
  localparam int PAL_LN    = 310;  // long frame
  localparam int TREND_MAX = 2**TREND_W - 1;

  logic               nCLK, nRST, nDSYNC_i;
  logic [COLOR_W-1:0] D_i;
  logic               wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  logic [ADDR_W-1:0]  wb_adr_i;
  logic [31:0]        wb_dat_i, wb_dat_o;
  logic               ndo_deblur_o;

  int err_cnt = 0;
  int tmo_cnt = 0;

  ////////////////////
  // reference model state

  sync_t      m_sync_prev;                            // last sync byte
  logic       m_nhs_prev, m_ncs_prev, m_blur_prev;    // last pixel
  logic       m_hflag_prev, m_i480, m_pal, m_run, m_est, m_ndo;
  logic       ndo_now;                                // what dut0 shows right now
  int         m_lines, m_rev, m_trend;
  logic [2:0] m_msb_prev [3];
  int         m_dir_blur [3];                         // -1 down, 0 flat, 1 up
  dbl_ctrl_t  m_ctrl;

  n64a_top #(.ADDR_W(ADDR_W)) dut0 (
    .nCLK(nCLK), .nRST(nRST), .nDSYNC_i(nDSYNC_i), .D_i(D_i),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .ndo_deblur_o(ndo_deblur_o)
  );

  initial begin
    nCLK = 1'b0;
    forever #50 nCLK = ~nCLK;  // 100 ns period
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %s exp %h act %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic end_run();
    $display("errors %0d, timeouts %0d", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  endtask

  ////////////////////
  // model

  // flags of the finished frame and then the trend step at each vsync fall
  task automatic model_frame();
    logic hflag;
    hflag        = ~m_nhs_prev;              // hsync low right before vsync
    m_pal        = (m_lines > PAL_LINE_TH);
    m_i480       = hflag ^ m_hflag_prev;
    m_hflag_prev = hflag;
    m_lines      = 0;
    if (!m_i480 && m_run) begin
      m_est = (m_trend >= (1 << (TREND_W-1)));  // msb before the step
      if (m_rev == 3)
        m_trend = (m_trend < TREND_MAX) ? m_trend + 1 : m_trend;
      else
        m_trend = (m_trend > 0) ? m_trend - 1 : 0;
    end
    m_rev = 0;
    m_run = ~m_i480;
    m_ndo = m_i480 | (m_ctrl.nforce_deblur ? m_est : m_ctrl.ndeblur_man);
  endtask

  task automatic model_pixel(input sync_t s, input logic [COLOR_W-1:0] r, g, b);
    logic [2:0] msb [3];
    int         dir [3];
    logic       blur_pos;
    logic       rev;
    msb[0] = r[COLOR_W-1 -: 3];
    msb[1] = g[COLOR_W-1 -: 3];
    msb[2] = b[COLOR_W-1 -: 3];
    rev = 1'b1;
    for (int i = 0; i < 3; i++) begin
      dir[i] = (msb[i] > m_msb_prev[i]) ? 1 : (msb[i] < m_msb_prev[i]) ? -1 : 0;
      if (dir[i] == 0 || dir[i] != -m_dir_blur[i])
        rev = 1'b0;  // every colour has to turn back
    end
    blur_pos = (~m_ncs_prev & s.ncsync) ? ~m_pal : ~m_blur_prev;
    if (!blur_pos && rev && m_rev < 3)
      m_rev++;
    if (m_nhs_prev && !s.nhsync)
      m_lines++;
    for (int i = 0; i < 3; i++) begin
      m_msb_prev[i] = msb[i];
      if (blur_pos)
        m_dir_blur[i] = dir[i];
    end
    m_blur_prev = blur_pos;
    m_ncs_prev  = s.ncsync;
    m_nhs_prev  = s.nhsync;
  endtask

  ////////////////////
  // video bus

  task automatic drive_byte(input logic nsync, input logic [COLOR_W-1:0] data);
    @(posedge nCLK);
    check_value("ndo_deblur_o", 32'(ndo_now), 32'(ndo_deblur_o));  // every cycle
    nDSYNC_i <= nsync;
    D_i      <= data;
  endtask

  task automatic send_pixel(input sync_t s, input logic [COLOR_W-1:0] r, g, b);
    if (m_sync_prev.nvsync && !s.nvsync)
      model_frame();
    m_sync_prev = s;
    drive_byte(1'b0, COLOR_W'(s));
    drive_byte(1'b1, r);
    drive_byte(1'b1, g);
    ndo_now = m_ndo;  // new decision visible at the b byte
    drive_byte(1'b1, b);
    model_pixel(s, r, g, b);
  endtask

  // a set half flag puts an hsync pulse just before vsync and flips per field in 480i
  task automatic send_frame(input int lines, input logic half, input logic sharp);
    sync_t              s;
    logic [COLOR_W-1:0] v;
    int                 base;
    base = $urandom % 16;
    s = '{nvsync: 1'b1, nclamp: 1'b1, nhsync: ~half, ncsync: ~half};
    send_pixel(s, '0, '0, '0);
    for (int l = 0; l < lines; l++) begin
      s = '{nvsync: (l >= 2), nclamp: 1'b1, nhsync: 1'b0, ncsync: 1'b0};  // 2 vsync lines
      send_pixel(s, '0, '0, '0);
      s.nhsync = 1'b1;
      s.ncsync = 1'b1;
      for (int p = 0; p < ACT_PX; p++) begin
        // sharp -> hi/lo zigzag, blurry -> slow ramp
        v = sharp ? ((p % 2) ? 7'h70 : 7'h08) : COLOR_W'(p * 8 + base);
        send_pixel(s, v | 3'($urandom), v | 3'($urandom), v | 3'($urandom));
      end
    end
  endtask

  ////////////////////
  // wishbone

  task automatic wb_access(input logic we, input int adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int n;
    @(posedge nCLK);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= ADDR_W'(adr);
    wb_dat_i <= wdat;
    n = 0;
    do begin
      @(posedge nCLK);
      n++;
    end while (!wb_ack_o && n < 20);
    if (!wb_ack_o) begin
      $display("wishbone access to address %0d got no ack within 20 cycles", adr);
      tmo_cnt++;
      end_run();
    end else begin
      rdat = wb_dat_o;
      wb_cyc_i <= 1'b0;  // stb drops the cycle after ack
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
      if (we && adr == REG_CTRL)
        m_ctrl = dbl_ctrl_t'(wdat[1:0]);
    end
  endtask

  task automatic read_stat(output logic [31:0] rd);
    wb_access(1'b0, REG_STAT, 32'h0, rd);
    check_value("REG_STAT", {28'd0, m_pal, m_i480, m_est, m_ndo}, rd);
  endtask

  ////////////////////
  // test sequence

  initial begin
    logic [31:0] rd;
    logic [31:0] wd;
    logic [31:0] st;
    void'($urandom(32'h2bf3));
    nRST = 1'b0;
    nDSYNC_i = 1'b1;
    D_i = '0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    m_sync_prev = '1;
    {m_nhs_prev, m_ncs_prev, m_blur_prev, m_hflag_prev} = 4'b1100;
    {m_i480, m_pal, m_run, m_est, m_ndo, ndo_now} = 6'b000111;
    m_lines = 0;
    m_rev = 0;
    m_trend = int'(TREND_INIT);
    m_msb_prev = '{3'd0, 3'd0, 3'd0};
    m_dir_blur = '{0, 0, 0};
    m_ctrl = 2'b11;
    repeat (16) @(posedge nCLK);
    nRST <= 1'b1;
    @(posedge nCLK);

    check_value("ndo_deblur_o", 32'h1, 32'(ndo_deblur_o));
    wb_access(1'b0, REG_CTRL, 32'h0, rd);
    check_value("REG_CTRL", 32'h3, rd);
    read_stat(rd);

    for (int k = 0; k < 8; k++) begin  // register access without video
      wd = $urandom;
      wb_access(1'b1, REG_CTRL, wd, rd);
      wb_access(1'b0, REG_CTRL, 32'h0, rd);
      check_value("REG_CTRL", {30'd0, wd[1:0]}, rd);
      read_stat(st);
      wb_access(1'b1, REG_STAT, $urandom, rd);  // ignored
      wb_access(1'b0, REG_STAT, 32'h0, rd);
      check_value("REG_STAT", st, rd);
      wb_access(1'b0, REG_CTRL, 32'h0, rd);  // control untouched by the status write
      check_value("REG_CTRL", {30'd0, wd[1:0]}, rd);
    end

    for (int k = 0; k < 4; k++) begin  // manual mode
      wd = $urandom % 2;
      wb_access(1'b1, REG_CTRL, {30'd0, 1'b0, wd[0]}, rd);
      send_frame(NTSC_LN, 1'b0, 1'($urandom));
      send_frame(NTSC_LN, 1'b0, 1'($urandom));
      check_value("ndo_deblur_o", {31'd0, wd[0]}, 32'(ndo_deblur_o));
    end

    wb_access(1'b1, REG_CTRL, 32'h3, rd);  // automatic 240p
    for (int k = 0; k < 12; k++) begin
      send_frame(NTSC_LN, 1'b0, 1'($urandom));
      read_stat(rd);
    end

    for (int k = 0; k < 6; k++) begin  // 480i with alternating fields
      send_frame(NTSC_LN, ~k[0], 1'($urandom));
      read_stat(rd);
      check_value("REG_STAT.n64_480i", 32'h1, {31'd0, rd[2]});
      check_value("ndo_deblur_o", 32'h1, 32'(ndo_deblur_o));
    end
    for (int k = 0; k < 4; k++) begin  // back to 240p
      send_frame(NTSC_LN, 1'b0, 1'($urandom));
      read_stat(rd);
    end

    for (int k = 0; k < 3; k++) begin  // PAL length frames
      send_frame(PAL_LN, 1'b0, 1'($urandom));
      read_stat(rd);
    end
    check_value("REG_STAT.pal", 32'h1, {31'd0, rd[3]});
    send_frame(NTSC_LN, 1'b0, 1'b1);
    read_stat(rd);
    end_run();
  end

endmodule

// File: sources.f
rtl/n64a_pkg.sv
rtl/n64_vdemux.sv
rtl/n64_vinfo.sv
rtl/n64_deblur.sv
rtl/n64a_cfg_wb.sv
rtl/n64a_top.sv
tb/tb_n64a.sv

// File: Bender.yml
package:
  name: n64a_video

sources:
  - target: any(rtl, test)
    files:
      - rtl/n64a_pkg.sv
      - rtl/n64_vdemux.sv
      - rtl/n64_vinfo.sv
      - rtl/n64_deblur.sv
      - rtl/n64a_cfg_wb.sv
      - rtl/n64a_top.sv
  - target: test
    files:
      - tb/tb_n64a.sv
